// ==== compile.f ====
src/cart_types_pkg.sv
src/cart_device_pkg.sv
src/block_config.sv
src/mapper_ascii8.sv
src/mapper_ascii16.sv
src/mapper_konami_scc.sv
src/mappers.sv
src/cart_slot.sv
testbench/cart_checker.sv
testbench/tb_cart_slot.sv

// ==== src/block_config.sv ====
`timescale 1ns/100ps
`default_nettype none

module block_config (
    input  wire                                    clk,
    input  wire                                    rst_n,
    input  wire                                    cfg_wr,        // Configuration strobe
    input  wire cart_types_pkg::mapper_t           cfg_type,
    input  wire [cart_types_pkg::SIZE_W-1:0]       cfg_size_log,
    input  wire                                    cfg_sram_en,
    output cart_types_pkg::mapper_t                cur_type,
    output logic [cart_types_pkg::SIZE_W-1:0]      rom_size_log,
    output logic                                   sram_en
);

    // Block information of the slot, valid from the cycle after cfg_wr
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cur_type     <= cart_types_pkg::MAP_NONE;
            rom_size_log <= cart_types_pkg::SIZE_W'(cart_types_pkg::SIZE_LOG_MAX);
            sram_en      <= 1'b0;
        end else if (cfg_wr) begin
            cur_type     <= cfg_type;
            rom_size_log <= cfg_size_log;
            sram_en      <= cfg_sram_en;
        end
    end

    // A latched size must describe a ROM between 8 KB and 4 MB
    a_size_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        cfg_wr |=> (rom_size_log >= cart_types_pkg::SIZE_LOG_MIN)
                && (rom_size_log <= cart_types_pkg::SIZE_LOG_MAX)
    ) else $error("block_config: rom_size_log %0d out of range", rom_size_log);

endmodule

`default_nettype wire

// ==== src/cart_device_pkg.sv ====
`default_nettype none

package cart_device_pkg;

    // Sound device attached to the cartridge
    typedef enum logic {
        DEV_NONE = 1'b0,
        DEV_SCC  = 1'b1
    } device_t;

    // Bank 2 value that maps the SCC registers in
    localparam logic [7:0] SCC_ENABLE_BANK = 8'h3F;

    // SCC register window inside page 2
    localparam logic [15:0] SCC_WIN_LO = 16'h9800;
    localparam logic [15:0] SCC_WIN_HI = 16'h9FFF;

endpackage

`default_nettype wire

// ==== src/cart_slot.sv ====
`timescale 1ns/100ps
`default_nettype none

module cart_slot (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire [15:0]                           addr,
    input  wire [7:0]                            data_in,
    input  wire                                  mreq,
    input  wire                                  wr,
    input  wire                                  rd,
    input  wire                                  cfg_wr,
    input  wire cart_types_pkg::mapper_t         cfg_type,
    input  wire [cart_types_pkg::SIZE_W-1:0]     cfg_size_log,
    input  wire                                  cfg_sram_en,
    output logic [cart_types_pkg::MEM_AW-1:0]    mem_addr,
    output logic                                 mem_rnw,
    output logic                                 ram_cs,
    output logic                                 sram_cs,
    output logic                                 dev_en,
    output logic                                 dev_we,
    output cart_device_pkg::device_t             dev_typ
);

    cart_types_pkg::mapper_t               cur_type;
    logic [cart_types_pkg::SIZE_W-1:0]     rom_size_log;
    logic                                  sram_en;

    block_config block_config_i (
        .clk(clk), .rst_n(rst_n),
        .cfg_wr(cfg_wr), .cfg_type(cfg_type),
        .cfg_size_log(cfg_size_log), .cfg_sram_en(cfg_sram_en),
        .cur_type(cur_type), .rom_size_log(rom_size_log), .sram_en(sram_en)
    );

    mappers mappers_i (
        .clk(clk), .rst_n(rst_n),
        .addr(addr), .data_in(data_in), .mreq(mreq), .wr(wr), .rd(rd),
        .cur_type(cur_type), .rom_size_log(rom_size_log), .sram_en(sram_en),
        .mem_addr(mem_addr), .mem_rnw(mem_rnw), .ram_cs(ram_cs), .sram_cs(sram_cs),
        .dev_en(dev_en), .dev_we(dev_we), .dev_typ(dev_typ)
    );

endmodule

`default_nettype wire

// ==== src/cart_types_pkg.sv ====
`default_nettype none

package cart_types_pkg;

    // External memory and bank register geometry
    localparam int MEM_AW = 22;         // 4 MB address space
    localparam int BANK_W = 8;          // Bank register width
    localparam int SIZE_W = 5;          // Width of the log2 ROM size field

    // Legal range of the log2 ROM size
    localparam int SIZE_LOG_MIN = 13;   // 8 KB
    localparam int SIZE_LOG_MAX = 22;   // 4 MB

    // Offset bits inside one bank window
    localparam int PAGE8_W  = 13;       // 8 KB windows
    localparam int PAGE16_W = 14;       // 16 KB windows

    // Number of SRAM bank bits used by ASCII8
    localparam int SRAM_BANK_W = 2;

    // Active mapper of the slot
    typedef enum logic [1:0] {
        MAP_NONE       = 2'd0,
        MAP_ASCII8     = 2'd1,
        MAP_ASCII16    = 2'd2,
        MAP_KONAMI_SCC = 2'd3
    } mapper_t;

endpackage

`default_nettype wire

// ==== src/mapper_ascii16.sv ====
`timescale 1ns/100ps
`default_nettype none

module mapper_ascii16 (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire [15:0]                           addr,
    input  wire [7:0]                            data_in,
    input  wire                                  mreq,
    input  wire                                  wr,
    input  wire                                  rd,
    input  wire cart_types_pkg::mapper_t         cur_type,
    output logic [cart_types_pkg::MEM_AW-1:0]    m_addr,
    output logic                                 m_rnw,
    output logic                                 m_ram_cs
);

    logic                                active;
    logic                                access;
    logic                                in_window;
    logic                                bank0_we;
    logic                                bank1_we;
    logic [cart_types_pkg::BANK_W-1:0]   bank0;     // Window 4000-7FFF
    logic [cart_types_pkg::BANK_W-1:0]   bank1;     // Window 8000-BFFF
    logic [cart_types_pkg::BANK_W-1:0]   cur_bank;

    assign active    = (cur_type == cart_types_pkg::MAP_ASCII16);
    assign access    = mreq && (rd || wr);
    assign in_window = (addr[15:14] == 2'b01) || (addr[15:14] == 2'b10);
    assign cur_bank  = addr[15] ? bank1 : bank0;

    // 6000-67FF and 7000-77FF
    assign bank0_we = active && mreq && wr && (addr[15:11] == 5'b01100);
    assign bank1_we = active && mreq && wr && (addr[15:11] == 5'b01110);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bank0 <= '0;
            bank1 <= '0;
        end else begin
            if (bank0_we) begin
                bank0 <= data_in;
            end
            if (bank1_we) begin
                bank1 <= data_in;
            end
        end
    end

    always_comb begin
        m_addr   = '1;
        m_rnw    = 1'b1;    // ROM only
        m_ram_cs = 1'b0;
        if (active && access && in_window) begin
            m_addr   = {cur_bank, addr[cart_types_pkg::PAGE16_W-1:0]};  // Bank x 16 KB
            m_ram_cs = 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== src/mapper_ascii8.sv ====
`timescale 1ns/100ps
`default_nettype none

module mapper_ascii8 (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire [15:0]                           addr,
    input  wire [7:0]                            data_in,
    input  wire                                  mreq,
    input  wire                                  wr,
    input  wire                                  rd,
    input  wire cart_types_pkg::mapper_t         cur_type,
    input  wire                                  sram_en,
    output logic [cart_types_pkg::MEM_AW-1:0]    m_addr,
    output logic                                 m_rnw,
    output logic                                 m_ram_cs,
    output logic                                 m_sram_cs
);

    logic                                active;
    logic                                access;
    logic                                in_window;
    logic                                bank_we;
    logic                                sram_hit;
    logic [1:0]                          win_sel;
    logic [cart_types_pkg::BANK_W-1:0]   bank [0:3];
    logic [cart_types_pkg::BANK_W-1:0]   cur_bank;

    assign active    = (cur_type == cart_types_pkg::MAP_ASCII8);
    assign access    = mreq && (rd || wr);
    assign in_window = (addr[15:14] == 2'b01) || (addr[15:14] == 2'b10);   // 4000-BFFF
    assign win_sel   = {addr[15], addr[13]};                               // 4000/6000/8000/A000
    assign cur_bank  = bank[win_sel];

    // Bank selects at 6000, 6800, 7000 and 7800
    assign bank_we  = active && mreq && wr && (addr[15:13] == 3'b011);

    // Bit 7 of the bank maps SRAM into the upper two windows
    assign sram_hit = sram_en && cur_bank[cart_types_pkg::BANK_W-1] && addr[15];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                bank[i] <= '0;
            end
        end else if (bank_we) begin
            bank[addr[12:11]] <= data_in;
        end
    end

    always_comb begin
        m_addr    = '1;     // Inactive value for the AND combiner
        m_rnw     = 1'b1;
        m_ram_cs  = 1'b0;
        m_sram_cs = 1'b0;
        if (active && access && in_window) begin
            if (sram_hit) begin
                m_addr = {{(cart_types_pkg::MEM_AW - cart_types_pkg::SRAM_BANK_W
                            - cart_types_pkg::PAGE8_W){1'b0}},
                          cur_bank[cart_types_pkg::SRAM_BANK_W-1:0],
                          addr[cart_types_pkg::PAGE8_W-1:0]};
                m_rnw     = rd;     // SRAM is writable
                m_sram_cs = 1'b1;
            end else begin
                m_addr = {{(cart_types_pkg::MEM_AW - cart_types_pkg::BANK_W
                            - cart_types_pkg::PAGE8_W){1'b0}},
                          cur_bank, addr[cart_types_pkg::PAGE8_W-1:0]};
                m_ram_cs = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/mapper_konami_scc.sv ====
`timescale 1ns/100ps
`default_nettype none

module mapper_konami_scc (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire [15:0]                           addr,
    input  wire [7:0]                            data_in,
    input  wire                                  mreq,
    input  wire                                  wr,
    input  wire                                  rd,
    input  wire cart_types_pkg::mapper_t         cur_type,
    output logic [cart_types_pkg::MEM_AW-1:0]    m_addr,
    output logic                                 m_rnw,
    output logic                                 m_ram_cs,
    output logic                                 m_dev_en,
    output logic                                 m_dev_we
);

    logic                                active;
    logic                                access;
    logic                                in_window;
    logic                                bank_we;
    logic                                scc_hit;
    logic [1:0]                          win_sel;
    logic [cart_types_pkg::BANK_W-1:0]   bank [0:3];
    logic [cart_types_pkg::BANK_W-1:0]   cur_bank;

    assign active    = (cur_type == cart_types_pkg::MAP_KONAMI_SCC);
    assign access    = mreq && (rd || wr);
    assign in_window = (addr[15:14] == 2'b01) || (addr[15:14] == 2'b10);
    assign win_sel   = {addr[15], addr[13]};
    assign cur_bank  = bank[win_sel];

    // Bank selects of 2 KB each at 5000, 7000, 9000 and B000
    assign bank_we = active && mreq && wr && in_window && (addr[12:11] == 2'b10);

    // SCC registers appear once bank 2 holds the enable value
    assign scc_hit = (bank[2] == cart_device_pkg::SCC_ENABLE_BANK)
                  && (addr >= cart_device_pkg::SCC_WIN_LO)
                  && (addr <= cart_device_pkg::SCC_WIN_HI);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                bank[i] <= i[cart_types_pkg::BANK_W-1:0];     // Linear map 0..3
            end
        end else if (bank_we) begin
            bank[win_sel] <= data_in;
        end
    end

    always_comb begin
        m_addr   = '1;
        m_rnw    = 1'b1;
        m_ram_cs = 1'b0;
        m_dev_en = 1'b0;
        m_dev_we = 1'b0;
        if (active && access && in_window) begin
            if (scc_hit) begin
                m_dev_en = 1'b1;    // Memory stays idle
                m_dev_we = wr;
            end else begin
                m_addr = {{(cart_types_pkg::MEM_AW - cart_types_pkg::BANK_W
                            - cart_types_pkg::PAGE8_W){1'b0}},
                          cur_bank, addr[cart_types_pkg::PAGE8_W-1:0]};
                m_ram_cs = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/mappers.sv ====
`timescale 1ns/100ps
`default_nettype none

module mappers (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire [15:0]                           addr,
    input  wire [7:0]                            data_in,
    input  wire                                  mreq,
    input  wire                                  wr,
    input  wire                                  rd,
    input  wire cart_types_pkg::mapper_t         cur_type,
    input  wire [cart_types_pkg::SIZE_W-1:0]     rom_size_log,
    input  wire                                  sram_en,
    output logic [cart_types_pkg::MEM_AW-1:0]    mem_addr,
    output logic                                 mem_rnw,
    output logic                                 ram_cs,
    output logic                                 sram_cs,
    output logic                                 dev_en,
    output logic                                 dev_we,
    output cart_device_pkg::device_t             dev_typ
);

    logic [cart_types_pkg::MEM_AW-1:0]   a8_addr;
    logic                                a8_rnw;
    logic                                a8_ram_cs;
    logic                                a8_sram_cs;
    logic [cart_types_pkg::MEM_AW-1:0]   a16_addr;
    logic                                a16_rnw;
    logic                                a16_ram_cs;
    logic [cart_types_pkg::MEM_AW-1:0]   scc_addr;
    logic                                scc_rnw;
    logic                                scc_ram_cs;
    logic                                scc_dev_en;
    logic                                scc_dev_we;
    logic [cart_types_pkg::MEM_AW-1:0]   addr_all;
    logic [cart_types_pkg::MEM_AW-1:0]   size_mask;

    mapper_ascii8 ascii8 (
        .clk(clk), .rst_n(rst_n),
        .addr(addr), .data_in(data_in), .mreq(mreq), .wr(wr), .rd(rd),
        .cur_type(cur_type), .sram_en(sram_en),
        .m_addr(a8_addr), .m_rnw(a8_rnw), .m_ram_cs(a8_ram_cs), .m_sram_cs(a8_sram_cs)
    );

    mapper_ascii16 ascii16 (
        .clk(clk), .rst_n(rst_n),
        .addr(addr), .data_in(data_in), .mreq(mreq), .wr(wr), .rd(rd),
        .cur_type(cur_type),
        .m_addr(a16_addr), .m_rnw(a16_rnw), .m_ram_cs(a16_ram_cs)
    );

    mapper_konami_scc konami_scc (
        .clk(clk), .rst_n(rst_n),
        .addr(addr), .data_in(data_in), .mreq(mreq), .wr(wr), .rd(rd),
        .cur_type(cur_type),
        .m_addr(scc_addr), .m_rnw(scc_rnw), .m_ram_cs(scc_ram_cs),
        .m_dev_en(scc_dev_en), .m_dev_we(scc_dev_we)
    );

    // Inactive mappers drive all ones, so the active one wins the AND
    assign addr_all  = a8_addr & a16_addr & scc_addr;
    assign size_mask = ~({cart_types_pkg::MEM_AW{1'b1}} << rom_size_log);   // Wraps banks past ROM end
    assign mem_addr  = ram_cs ? (addr_all & size_mask) : addr_all;

    assign mem_rnw = a8_rnw & a16_rnw & scc_rnw;
    assign ram_cs  = a8_ram_cs | a16_ram_cs | scc_ram_cs;
    assign sram_cs = a8_sram_cs;
    assign dev_en  = scc_dev_en;
    assign dev_we  = scc_dev_we;

    assign dev_typ = (mreq && (cur_type == cart_types_pkg::MAP_KONAMI_SCC))
                   ? cart_device_pkg::DEV_SCC : cart_device_pkg::DEV_NONE;

    // Only one memory device may be selected across all mappers
    a_cs_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(ram_cs && sram_cs)
    ) else $error("mappers: ram_cs and sram_cs both active");

endmodule

`default_nettype wire

// ==== testbench/cart_cases.txt ====
# op addr data chk exp_addr rnw ram_cs sram_cs dev_en dev_typ  (all hex)
# CFG rows: addr = 100 * sram_en + mapper type, data = log2 of ROM size
RD  4000 00 1 3FFFFF 1 0 0 0 0
CFG 0001 11 0 000000 0 0 0 0 0
WR  6000 03 0 000000 0 0 0 0 0
WR  6800 05 0 000000 0 0 0 0 0
WR  7000 0A 0 000000 0 0 0 0 0
WR  7800 0F 0 000000 0 0 0 0 0
RD  4000 00 1 006000 1 1 0 0 0
RD  6010 00 1 00A010 1 1 0 0 0
RD  8123 00 1 014123 1 1 0 0 0
RD  A456 00 1 01E456 1 1 0 0 0
WR  7800 13 0 000000 0 0 0 0 0
RD  BFFF 00 1 007FFF 1 1 0 0 0
RD  C000 00 1 3FFFFF 1 0 0 0 0
CFG 0101 11 0 000000 0 0 0 0 0
WR  7000 80 0 000000 0 0 0 0 0
WR  8000 5A 1 000000 0 0 1 0 0
CFG 0002 12 0 000000 0 0 0 0 0
WR  6000 02 0 000000 0 0 0 0 0
WR  7000 05 0 000000 0 0 0 0 0
RD  4000 00 1 008000 1 1 0 0 0
RD  8ABC 00 1 014ABC 1 1 0 0 0
WR  6800 07 0 000000 0 0 0 0 0
WR  5000 07 0 000000 0 0 0 0 0
RD  7FFF 00 1 00BFFF 1 1 0 0 0
RD  BFFF 00 1 017FFF 1 1 0 0 0
CFG 0003 16 0 000000 0 0 0 0 0
RD  4000 00 1 000000 1 1 0 0 1
RD  6001 00 1 002001 1 1 0 0 1
RD  A003 00 1 006003 1 1 0 0 1
WR  9000 3F 0 000000 0 0 0 0 0
RD  9800 00 1 3FFFFF 1 0 0 1 1
WR  9C00 12 1 3FFFFF 1 0 0 1 1
RD  8000 00 1 07E000 1 1 0 0 1
CFG 0002 12 0 000000 0 0 0 0 0
RD  9800 00 1 015800 1 1 0 0 0

// ==== testbench/cart_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module cart_checker (
    input  wire                                  clk,
    input  wire                                  check_en,     // Expected values valid this cycle
    input  wire [31:0]                           case_id,
    input  wire [cart_types_pkg::MEM_AW-1:0]     exp_addr,
    input  wire                                  exp_rnw,
    input  wire                                  exp_ram_cs,
    input  wire                                  exp_sram_cs,
    input  wire                                  exp_dev_en,
    input  wire                                  exp_dev_we,
    input  wire cart_device_pkg::device_t        exp_dev_typ,
    input  wire [cart_types_pkg::MEM_AW-1:0]     mem_addr,
    input  wire                                  mem_rnw,
    input  wire                                  ram_cs,
    input  wire                                  sram_cs,
    input  wire                                  dev_en,
    input  wire                                  dev_we,
    input  wire cart_device_pkg::device_t        dev_typ,
    input  wire                                  report,       // Rising edge prints the counts
    output int                                   checked_count,
    output int                                   failed_count
);

    logic case_bad;

    task automatic check_field(input string name, input logic [21:0] expected,
                               input logic [21:0] actual);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
            case_bad = 1'b1;
        end
    endtask

    initial begin
        checked_count = 0;
        failed_count  = 0;
        case_bad      = 1'b0;
    end

    // Outputs have settled since the falling edge and flops move only after this read
    always @(posedge clk) begin
        if (check_en) begin
            case_bad = 1'b0;
            check_field("mem_addr", exp_addr, mem_addr);
            check_field("mem_rnw", exp_rnw, mem_rnw);
            check_field("ram_cs", exp_ram_cs, ram_cs);
            check_field("sram_cs", exp_sram_cs, sram_cs);
            check_field("dev_en", exp_dev_en, dev_en);
            check_field("dev_we", exp_dev_we, dev_we);
            check_field("dev_typ", exp_dev_typ, dev_typ);
            checked_count++;
            if (case_bad) begin
                failed_count++;
                $display("Case %0d: failed", case_id);
            end else begin
                $display("Case %0d: passed", case_id);
            end
        end
    end

    always @(posedge report) begin
        $display("Cases checked: %0d, passed: %0d, failed: %0d",
                 checked_count, checked_count - failed_count, failed_count);
    end

endmodule

`default_nettype wire

// ==== testbench/tb_cart_slot.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_cart_slot;

    localparam int MAX_CASES = 64;

    logic                                  clk;
    logic                                  rst_n;
    logic [15:0]                           addr;
    logic [7:0]                            data_in;
    logic                                  mreq;
    logic                                  wr;
    logic                                  rd;
    logic                                  cfg_wr;
    cart_types_pkg::mapper_t               cfg_type;
    logic [cart_types_pkg::SIZE_W-1:0]     cfg_size_log;
    logic                                  cfg_sram_en;
    logic [cart_types_pkg::MEM_AW-1:0]     mem_addr;
    logic                                  mem_rnw;
    logic                                  ram_cs;
    logic                                  sram_cs;
    logic                                  dev_en;
    logic                                  dev_we;
    cart_device_pkg::device_t              dev_typ;

    logic                                  check_en;
    logic [31:0]                           case_id;
    logic [cart_types_pkg::MEM_AW-1:0]     exp_addr;
    logic [3:0]                            exp_flags;    // rnw, ram_cs, sram_cs, dev_en
    logic                                  exp_dev_we;
    cart_device_pkg::device_t              exp_dev_typ;
    logic                                  report;
    int                                    checked_count;
    int                                    failed_count;

    // Case table with op 0 for CFG, 1 for WR and 2 for RD
    int                                    op_tab    [0:MAX_CASES-1];
    logic [15:0]                           addr_tab  [0:MAX_CASES-1];
    logic [7:0]                            data_tab  [0:MAX_CASES-1];
    logic                                  chk_tab   [0:MAX_CASES-1];
    logic [cart_types_pkg::MEM_AW-1:0]     eaddr_tab [0:MAX_CASES-1];
    logic [4:0]                            eflag_tab [0:MAX_CASES-1];
    int                                    num_cases;
    int                                    cycle_limit = 0;
    int                                    cycle_count = 0;
    int unsigned                           rand_seed;

    cart_slot cart_slot_i (
        .clk(clk), .rst_n(rst_n),
        .addr(addr), .data_in(data_in), .mreq(mreq), .wr(wr), .rd(rd),
        .cfg_wr(cfg_wr), .cfg_type(cfg_type), .cfg_size_log(cfg_size_log),
        .cfg_sram_en(cfg_sram_en),
        .mem_addr(mem_addr), .mem_rnw(mem_rnw), .ram_cs(ram_cs), .sram_cs(sram_cs),
        .dev_en(dev_en), .dev_we(dev_we), .dev_typ(dev_typ)
    );

    cart_checker cart_checker_i (
        .clk(clk), .check_en(check_en), .case_id(case_id),
        .exp_addr(exp_addr), .exp_rnw(exp_flags[3]), .exp_ram_cs(exp_flags[2]),
        .exp_sram_cs(exp_flags[1]), .exp_dev_en(exp_flags[0]), .exp_dev_we(exp_dev_we),
        .exp_dev_typ(exp_dev_typ),
        .mem_addr(mem_addr), .mem_rnw(mem_rnw), .ram_cs(ram_cs), .sram_cs(sram_cs),
        .dev_en(dev_en), .dev_we(dev_we), .dev_typ(dev_typ), .report(report),
        .checked_count(checked_count), .failed_count(failed_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic load_cases(output bit ok);
        int          fd;
        int          n;
        string       line;
        logic [31:0] op_name;
        logic [15:0] a;
        logic [7:0]  d;
        logic        c;
        logic [21:0] ea;
        logic        r;
        logic        m;
        logic        s;
        logic        e;
        logic        t;
        ok = 1'b0;
        num_cases = 0;
        fd = $fopen("testbench/cart_cases.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while (!$feof(fd) && num_cases < MAX_CASES) begin
                line = "";
                n = $fgets(line, fd);
                n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h",
                            op_name, a, d, c, ea, r, m, s, e, t);
                if (n == 10) begin     // Comment and blank lines parse short
                    if (op_name == "CFG") op_tab[num_cases] = 0;
                    else if (op_name == "WR") op_tab[num_cases] = 1;
                    else if (op_name == "RD") op_tab[num_cases] = 2;
                    else begin
                        $display("Unknown operation on case line %0d", num_cases + 1);
                        ok = 1'b0;
                    end
                    addr_tab[num_cases]  = a;
                    data_tab[num_cases]  = d;
                    chk_tab[num_cases]   = c;
                    eaddr_tab[num_cases] = ea;
                    eflag_tab[num_cases] = {r, m, s, e, t};
                    num_cases++;
                end
            end
            $fclose(fd);
        end
    endtask

    // Drives one case from a falling edge and leaves it idle for 0 to 3 cycles
    task automatic run_case(input int idx);
        int idle;
        case_id = idx + 1;
        if (op_tab[idx] == 0) begin
            cfg_wr       = 1'b1;
            cfg_type     = cart_types_pkg::mapper_t'(addr_tab[idx][1:0]);
            cfg_sram_en  = addr_tab[idx][8];
            cfg_size_log = data_tab[idx][cart_types_pkg::SIZE_W-1:0];
        end else begin
            addr    = addr_tab[idx];
            data_in = data_tab[idx];
            mreq    = 1'b1;
            wr      = (op_tab[idx] == 1);
            rd      = (op_tab[idx] == 2);
        end
        check_en    = chk_tab[idx];
        exp_addr    = eaddr_tab[idx];
        exp_flags   = eflag_tab[idx][4:1];
        exp_dev_we  = (op_tab[idx] == 1) && eflag_tab[idx][1];  // SCC write follows wr
        exp_dev_typ = cart_device_pkg::device_t'(eflag_tab[idx][0]);
        @(negedge clk);
        mreq     = 1'b0;
        wr       = 1'b0;
        rd       = 1'b0;
        cfg_wr   = 1'b0;
        check_en = 1'b0;
        idle = $urandom % 4;
        repeat (idle) @(negedge clk);
    endtask

    initial begin
        bit ok;
        rst_n        = 1'b0;
        addr         = 16'h0000;
        data_in      = 8'h00;
        mreq         = 1'b0;
        wr           = 1'b0;
        rd           = 1'b0;
        cfg_wr       = 1'b0;
        cfg_type     = cart_types_pkg::MAP_NONE;
        cfg_size_log = '0;
        cfg_sram_en  = 1'b0;
        check_en     = 1'b0;
        case_id      = '0;
        exp_addr     = '0;
        exp_flags    = '0;
        exp_dev_we   = 1'b0;
        exp_dev_typ  = cart_device_pkg::DEV_NONE;
        report       = 1'b0;
        rand_seed    = 32'h4066_80f0;
        void'($urandom(rand_seed));
        load_cases(ok);
        if (!ok) begin
            $display("Case file is missing or holds a bad line");
            $display("Checks failed");
            $finish;
        end else begin
            cycle_limit = num_cases * 8 + 20;
            repeat (3) @(negedge clk);
            rst_n = 1'b1;
            for (int i = 0; i < num_cases; i++) begin
                run_case(i);
            end
            report = 1'b1;
            @(posedge clk);
            if (failed_count == 0 && checked_count > 0) begin
                $display("All checks passed");
            end else begin
                $display("Checks failed");
            end
            $finish;
        end
    end

    // Run length bound armed once the case count is known
    initial begin
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Run timed out after %0d cycles", cycle_count);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire
